/* logic/board_pkg.sv */
`default_nettype none

package board_pkg;

	//////////////////////////////////////////////////
	// Front panel LEDs, top to bottom
	//////////////////////////////////////////////////

	localparam int LED_COUNT = 4;

	// Yellow, token error or board reset
	localparam int LED_ERR    = 0;
	// Green, CPLD access line
	localparam int LED_ACCESS = 1;
	// Green, master trigger token received
	localparam int LED_TRIG   = 2;
	// Green, lit while no inhibit
	localparam int LED_NOINH  = 3;

	//////////////////////////////////////////////////
	// Timing at 125 MHz
	//////////////////////////////////////////////////

	// Hold reset after configuration
	localparam int POWERUP_CYCLES_DEF = 1_000_000;
	// LED on-time, about 0.1 s
	localparam int STRETCH_CYCLES_DEF = 12_500_000;

endpackage

`default_nettype wire

/* logic/token_pkg.sv */
`default_nettype none

package token_pkg;

	//////////////////////////////////////////////////
	// Master trigger token
	//////////////////////////////////////////////////

	localparam int TOKEN_W = 10;

	typedef logic [TOKEN_W-1:0] token_t;

	//////////////////////////////////////////////////
	// Transceiver lane words
	//////////////////////////////////////////////////

	// Default lane count of the GTP tile
	localparam int LANES  = 4;
	localparam int LANE_W = 16;

	typedef logic [LANE_W-1:0] lane_word_t;

	// Idle word, K28.5 in the low byte
	localparam lane_word_t COMMA_WORD = 16'h00BC;

	// Reply prefix, then error bit, then token
	localparam logic [4:0] REPLY_MARK = 5'b10000;

endpackage

`default_nettype wire

/* logic/reset_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_gen import board_pkg::*; #(
	parameter int POWERUP_CYCLES = POWERUP_CYCLES_DEF
) (
	input  logic CLK125,
	input  logic reset_i,
	input  logic ext_rst_n_i,
	output logic sys_rst_o
);

	localparam int CNT_W = $clog2(POWERUP_CYCLES + 1);

	// Power-up hold counter
	logic [CNT_W-1:0] pwr_cnt;
	logic             hold_done;

	assign hold_done = (pwr_cnt == CNT_W'(POWERUP_CYCLES));

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			pwr_cnt   <= '0;
			sys_rst_o <= 1'b1;
		end else if (!hold_done) begin
			// Still counting, keep board in reset
			pwr_cnt   <= pwr_cnt + 1'b1;
			sys_rst_o <= 1'b1;
		end else begin
			// Follow CPLD global reset, active low
			sys_rst_o <= ~ext_rst_n_i;
		end
	end

	// No release before the hold count is reached
	a_hold_rst : assert property (@(posedge CLK125) disable iff (reset_i)
		!hold_done |-> sys_rst_o);

endmodule

`default_nettype wire

/* logic/token_rcv.sv */
`timescale 1ns/1ps
`default_nettype none

module token_rcv import token_pkg::*; (
	input  logic   CLK125,
	input  logic   sys_rst_i,
	input  logic   ser_trig_i,
	output token_t tok_o,
	output logic   tok_rdy_o,
	output logic   tok_err_o
);

	localparam int BIT_CNT_W = $clog2(TOKEN_W);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} state_t;

	state_t               state;
	logic [1:0]           ser_sync;
	logic                 ser_q;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic                 par;
	token_t               shreg;

	//////////////////////////////////////////////////
	// Two-flop synchronizer on the neighbour FPGA line
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (sys_rst_i) begin
			ser_sync <= '0;
		end else begin
			ser_sync <= {ser_sync[0], ser_trig_i};
		end
	end

	assign ser_q = ser_sync[1];

	//////////////////////////////////////////////////
	// Frame FSM over start, 10 data LSB first, parity and stop
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (sys_rst_i) begin
			state     <= ST_IDLE;
			bit_cnt   <= '0;
			par       <= 1'b0;
			tok_rdy_o <= 1'b0;
			tok_err_o <= 1'b0;
		end else begin
			// Strobes last a single cycle
			tok_rdy_o <= 1'b0;
			tok_err_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (ser_q) begin
						state   <= ST_DATA;
						bit_cnt <= '0;
						par     <= 1'b0;
					end
				end
				ST_DATA: begin
					par     <= par ^ ser_q;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_CNT_W'(TOKEN_W - 1))
						state <= ST_PARITY;
				end
				ST_PARITY: begin
					// Odd ones over token and parity
					par   <= par ^ ser_q;
					state <= ST_STOP;
				end
				ST_STOP: begin
					// Token reported even on error
					tok_rdy_o <= 1'b1;
					tok_err_o <= ser_q | ~par;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Token bits shift in from the top, LSB first
	always_ff @(posedge CLK125) begin
		if (state == ST_DATA)
			shreg <= {ser_q, shreg[TOKEN_W-1:1]};
	end

	assign tok_o = shreg;

	a_err_with_rdy : assert property (@(posedge CLK125) tok_err_o |-> tok_rdy_o);

endmodule

`default_nettype wire

/* logic/gtp_lane_io.sv */
`timescale 1ns/1ps
`default_nettype none

module gtp_lane_io import token_pkg::*; #(
	parameter int N_LANES = LANES
) (
	input  logic                      CLK125,
	input  logic                      sys_rst_i,
	input  token_t                    tok_i,
	input  logic                      tok_rdy_i,
	input  logic                      tok_err_i,
	input  logic [N_LANES*LANE_W-1:0] rx_data_i,
	input  logic [N_LANES-1:0]        rx_k_i,
	output logic [N_LANES*LANE_W-1:0] tx_data_o,
	output logic [N_LANES-1:0]        tx_k_o,
	output logic [N_LANES-1:0]        tp_o
);

	lane_word_t         tx_word;
	logic [N_LANES-1:0] tp_hit;
	logic [N_LANES-1:0] tp_q;

	//////////////////////////////////////////////////
	// Transmit side, same word on all lanes
	//////////////////////////////////////////////////

	// Marked reply word for one cycle, else comma
	assign tx_word = tok_rdy_i ? {REPLY_MARK, tok_err_i, tok_i} : COMMA_WORD;

	always_ff @(posedge CLK125) begin
		if (sys_rst_i) begin
			tx_data_o <= {N_LANES{COMMA_WORD}};
			tx_k_o    <= '1;
		end else begin
			tx_data_o <= {N_LANES{tx_word}};
			// Reply is plain data, comma is K
			tx_k_o    <= {N_LANES{~tok_rdy_i}};
		end
	end

	//////////////////////////////////////////////////
	// Receive test points
	//////////////////////////////////////////////////

	// K-char with top bit set on any lane
	always_comb begin
		for (int n = 0; n < N_LANES; n++)
			tp_hit[n] = rx_k_i[n] & rx_data_i[n*LANE_W + LANE_W - 1];
	end

	always_ff @(posedge CLK125) begin
		if (sys_rst_i) begin
			tp_q <= '0;
			tp_o <= '0;
		end else begin
			tp_q <= tp_hit;
			tp_o <= tp_q;
		end
	end

	a_k_lanes_equal : assert property (@(posedge CLK125)
		!$isunknown(tx_k_o) |-> (&tx_k_o || ~|tx_k_o));

endmodule

`default_nettype wire

/* logic/led_stretch.sv */
`timescale 1ns/1ps
`default_nettype none

module led_stretch import board_pkg::*; #(
	parameter int STRETCH_CYCLES = STRETCH_CYCLES_DEF
) (
	input  logic CLK125,
	input  logic rst_i,
	input  logic trig_i,
	output logic led_o
);

	localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

	logic [CNT_W-1:0] on_cnt;

	// Retriggerable, every trigger cycle reloads
	always_ff @(posedge CLK125) begin
		if (rst_i)
			on_cnt <= '0;
		else if (trig_i)
			on_cnt <= CNT_W'(STRETCH_CYCLES);
		else if (on_cnt != '0)
			on_cnt <= on_cnt - 1'b1;
	end

	assign led_o = (on_cnt != '0);

	// Error LED instance has no reset, skip until first load
	a_cnt_range : assert property (@(posedge CLK125)
		!$isunknown(on_cnt) |-> (on_cnt <= CNT_W'(STRETCH_CYCLES)));

endmodule

`default_nettype wire

/* logic/led_panel.sv */
`timescale 1ns/1ps
`default_nettype none

module led_panel import board_pkg::*; #(
	parameter int STRETCH_CYCLES = STRETCH_CYCLES_DEF
) (
	input  logic                 CLK125,
	input  logic                 sys_rst_i,
	input  logic                 tok_rdy_i,
	input  logic                 tok_err_i,
	input  logic                 vme_access_i,
	input  logic                 inhibit_i,
	output logic [LED_COUNT-1:0] led_o
);

	logic [LED_COUNT-1:0] led_src;

	//////////////////////////////////////////////////
	// LED sources
	//////////////////////////////////////////////////

	// Board reset or bad token frame
	assign led_src[LED_ERR]    = sys_rst_i | (tok_rdy_i & tok_err_i);
	// Access seen by the CPLD
	assign led_src[LED_ACCESS] = vme_access_i;
	assign led_src[LED_TRIG]   = tok_rdy_i;
	// Inhibit active high, LED shows its absence
	assign led_src[LED_NOINH]  = ~inhibit_i;

	for (genvar i = 0; i < LED_COUNT; i++) begin : g_led
		// Error LED keeps running through reset
		led_stretch #(
			.STRETCH_CYCLES (STRETCH_CYCLES)
		) u_stretch (
			.CLK125 (CLK125),
			.rst_i  ((i == LED_ERR) ? 1'b0 : sys_rst_i),
			.trig_i (led_src[i]),
			.led_o  (led_o[i])
		);
	end

endmodule

`default_nettype wire

/* logic/wfd_front.sv */
`timescale 1ns/1ps
`default_nettype none

module wfd_front import board_pkg::*, token_pkg::*; #(
	parameter int POWERUP_CYCLES = POWERUP_CYCLES_DEF,
	parameter int STRETCH_CYCLES = STRETCH_CYCLES_DEF,
	parameter int N_LANES        = LANES
) (
	input  logic                      CLK125,
	input  logic                      reset_i,
	input  logic                      ext_rst_n_i,
	input  logic                      vme_access_i,
	input  logic                      inhibit_i,
	input  logic                      ser_trig_i,
	input  logic [N_LANES*LANE_W-1:0] rx_data_i,
	input  logic [N_LANES-1:0]        rx_k_i,
	output logic [N_LANES*LANE_W-1:0] tx_data_o,
	output logic [N_LANES-1:0]        tx_k_o,
	output logic [N_LANES-1:0]        tp_o,
	output logic [LED_COUNT-1:0]      led_o
);

	logic   sys_rst;
	token_t tok;
	logic   tok_rdy;
	logic   tok_err;

	// Board reset, power-up hold then CPLD line
	reset_gen #(
		.POWERUP_CYCLES (POWERUP_CYCLES)
	) u_reset_gen (
		.CLK125      (CLK125),
		.reset_i     (reset_i),
		.ext_rst_n_i (ext_rst_n_i),
		.sys_rst_o   (sys_rst)
	);

	// Master trigger token from neighbour FPGA
	token_rcv u_token_rcv (
		.CLK125     (CLK125),
		.sys_rst_i  (sys_rst),
		.ser_trig_i (ser_trig_i),
		.tok_o      (tok),
		.tok_rdy_o  (tok_rdy),
		.tok_err_o  (tok_err)
	);

	// Token reply out, test points in
	gtp_lane_io #(
		.N_LANES (N_LANES)
	) u_gtp_lane_io (
		.CLK125    (CLK125),
		.sys_rst_i (sys_rst),
		.tok_i     (tok),
		.tok_rdy_i (tok_rdy),
		.tok_err_i (tok_err),
		.rx_data_i (rx_data_i),
		.rx_k_i    (rx_k_i),
		.tx_data_o (tx_data_o),
		.tx_k_o    (tx_k_o),
		.tp_o      (tp_o)
	);

	led_panel #(
		.STRETCH_CYCLES (STRETCH_CYCLES)
	) u_led_panel (
		.CLK125       (CLK125),
		.sys_rst_i    (sys_rst),
		.tok_rdy_i    (tok_rdy),
		.tok_err_i    (tok_err),
		.vme_access_i (vme_access_i),
		.inhibit_i    (inhibit_i),
		.led_o        (led_o)
	);

endmodule

`default_nettype wire

/* verification/tb_wfd_front.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wfd_front import board_pkg::*; ();

	localparam int PWR     = 40;
	localparam int STRETCH = 16;
	localparam int NL      = 4;
	// Idle lane word with K28.5 in low byte
	localparam logic [15:0] COMMA = 16'h00BC;

	// Rough cycle count of each test
	localparam int PWR_TEST_CYC = 3 + PWR + 2 * STRETCH + 30;
	localparam int TOK_TEST_CYC = 80;
	localparam int BAD_TEST_CYC = 50;
	localparam int TP_TEST_CYC  = 10;
	localparam int LED_TEST_CYC = 2 * STRETCH + 20;
	localparam int WATCHDOG_NS  = 2 * 10 *
		(PWR_TEST_CYC + TOK_TEST_CYC + BAD_TEST_CYC + TP_TEST_CYC + LED_TEST_CYC);

	logic              CLK125;
	logic              reset_i;
	logic              ext_rst_n_i;
	logic              vme_access_i;
	logic              inhibit_i;
	logic              ser_trig_i;
	logic [NL*16-1:0]  rx_data_i;
	logic [NL-1:0]     rx_k_i;
	logic [NL*16-1:0]  tx_data_o;
	logic [NL-1:0]     tx_k_o;
	logic [NL-1:0]     tp_o;
	logic [LED_COUNT-1:0] led_o;

	logic [15:0] lfsr;
	// Serial bits per cycle, stop-bit positions, expected replies
	bit          stream[$];
	int          stop_idx[$];
	logic [15:0] reply_word[$];

	wfd_front #(
		.POWERUP_CYCLES (PWR),
		.STRETCH_CYCLES (STRETCH),
		.N_LANES        (NL)
	) u_dut (
		.CLK125       (CLK125),
		.reset_i      (reset_i),
		.ext_rst_n_i  (ext_rst_n_i),
		.vme_access_i (vme_access_i),
		.inhibit_i    (inhibit_i),
		.ser_trig_i   (ser_trig_i),
		.rx_data_i    (rx_data_i),
		.rx_k_i       (rx_k_i),
		.tx_data_o    (tx_data_o),
		.tx_k_o       (tx_k_o),
		.tp_o         (tp_o),
		.led_o        (led_o)
	);

	// 125 MHz stand-in with 10 ns period
	initial begin
		CLK125 = 1'b0;
		forever #5 CLK125 = ~CLK125;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per token bit
	task automatic next_token(output logic [9:0] tok);
		for (int i = 0; i < 10; i++) begin
			lfsr = lfsr_next(lfsr);
			tok[i] = lfsr[0];
		end
	endtask

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1, "run stopped at first error");
		end
	endtask

	task automatic add_gap(input int n);
		repeat (n) stream.push_back(1'b0);
	endtask

	// Start, 10 bits LSB first, parity, stop
	task automatic add_frame(input logic [9:0] tok, input bit bad_par, input bit bad_stop);
		logic par;
		// Odd ones over token plus parity
		par = ~^tok ^ bad_par;
		stream.push_back(1'b1);
		for (int i = 0; i < 10; i++)
			stream.push_back(tok[i]);
		stream.push_back(par);
		stream.push_back(bad_stop);
		stop_idx.push_back(stream.size() - 1);
		reply_word.push_back({5'b10000, bad_par | bad_stop, tok});
	endtask

	// Reply due 4 edges after the stop-bit drive edge
	task automatic run_stream();
		logic [15:0] exp_word [];
		bit          exp_rep [];
		exp_word = new[stream.size()];
		exp_rep  = new[stream.size()];
		foreach (exp_word[c]) begin
			exp_word[c] = COMMA;
			exp_rep[c]  = 1'b0;
		end
		foreach (stop_idx[i]) begin
			exp_word[stop_idx[i] + 4] = reply_word[i];
			exp_rep[stop_idx[i] + 4]  = 1'b1;
		end
		foreach (stream[c]) begin
			@(posedge CLK125);
			ser_trig_i <= stream[c];
			@(negedge CLK125);
			check("tx_data_o", {NL{exp_word[c]}}, tx_data_o);
			check("tx_k_o", {NL{~exp_rep[c]}}, tx_k_o);
			if (exp_rep[c]) begin
				check("led_o[LED_TRIG]", 1, led_o[LED_TRIG]);
				// Error bit sits just above the token
				if (exp_word[c][10])
					check("led_o[LED_ERR]", 1, led_o[LED_ERR]);
			end
		end
		stream.delete();
		stop_idx.delete();
		reply_word.delete();
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic power_up_hold();
		repeat (3) @(posedge CLK125);
		reset_i <= 1'b0;
		// Board kept in reset for the hold window
		for (int c = 0; c < PWR; c++) begin
			@(negedge CLK125);
			check("led_o[LED_ERR]", 1, led_o[LED_ERR]);
			check("tx_data_o", {NL{COMMA}}, tx_data_o);
			check("tx_k_o", {NL{1'b1}}, tx_k_o);
		end
		repeat (STRETCH + 1) @(negedge CLK125);
		check("led_o[LED_ERR]", 1, led_o[LED_ERR]);
		@(negedge CLK125);
		check("led_o[LED_ERR]", 0, led_o[LED_ERR]);
		// CPLD pulls reset again
		@(posedge CLK125);
		ext_rst_n_i <= 1'b0;
		repeat (2) @(negedge CLK125);
		check("led_o[LED_ERR]", 0, led_o[LED_ERR]);
		@(negedge CLK125);
		check("led_o[LED_ERR]", 1, led_o[LED_ERR]);
		@(posedge CLK125);
		ext_rst_n_i <= 1'b1;
		repeat (STRETCH + 4) @(negedge CLK125);
		check("led_o[LED_ERR]", 0, led_o[LED_ERR]);
	endtask

	task automatic good_token_replies();
		logic [9:0] tok;
		add_gap(3);
		next_token(tok);
		add_frame(tok, 1'b0, 1'b0);
		add_gap(2);
		// Three frames back to back
		repeat (3) begin
			next_token(tok);
			add_frame(tok, 1'b0, 1'b0);
		end
		add_gap(8);
		run_stream();
	endtask

	task automatic bad_frame_replies();
		logic [9:0] tok;
		@(negedge CLK125);
		check("led_o[LED_ERR]", 0, led_o[LED_ERR]);
		add_gap(2);
		next_token(tok);
		add_frame(tok, 1'b1, 1'b0);
		add_gap(4);
		next_token(tok);
		add_frame(tok, 1'b0, 1'b1);
		add_gap(8);
		run_stream();
	endtask

	// Each lane walks through all rx_k and bit 15 pairs
	task automatic test_point_flags();
		logic [3:0] exp_tp [0:7];
		logic [1:0] combo;
		for (int c = 0; c < 8; c++) begin
			@(posedge CLK125);
			if (c < 4) begin
				for (int n = 0; n < NL; n++) begin
					combo = 2'((c + n) % 4);
					rx_k_i[n] <= combo[1];
					rx_data_i[n*16 +: 16] <= {combo[0], 15'h02BC};
					exp_tp[c][n] = combo[1] & combo[0];
				end
			end else begin
				rx_k_i    <= '0;
				rx_data_i <= '0;
				exp_tp[c] = '0;
			end
			@(negedge CLK125);
			check("tp_o", (c >= 2) ? exp_tp[c-2] : 4'h0, tp_o);
		end
	endtask

	task automatic led_stretch_times();
		@(posedge CLK125);
		vme_access_i <= 1'b1;
		@(posedge CLK125);
		vme_access_i <= 1'b0;
		// On for STRETCH cycles after the pulse
		for (int j = 0; j < STRETCH + 1; j++) begin
			@(negedge CLK125);
			check("led_o[LED_ACCESS]", (j < STRETCH) ? 1 : 0, led_o[LED_ACCESS]);
		end
		check("led_o[LED_NOINH]", 0, led_o[LED_NOINH]);
		@(posedge CLK125);
		inhibit_i <= 1'b0;
		repeat (4) @(negedge CLK125);
		check("led_o[LED_NOINH]", 1, led_o[LED_NOINH]);
		@(posedge CLK125);
		inhibit_i <= 1'b1;
		for (int j = 0; j < STRETCH + 1; j++) begin
			@(negedge CLK125);
			check("led_o[LED_NOINH]", (j < STRETCH) ? 1 : 0, led_o[LED_NOINH]);
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		reset_i      = 1'b1;
		ext_rst_n_i  = 1'b1;
		vme_access_i = 1'b0;
		inhibit_i    = 1'b1;
		ser_trig_i   = 1'b0;
		rx_data_i    = '0;
		rx_k_i       = '0;
		lfsr         = 16'd28;
		power_up_hold();
		good_token_replies();
		bad_frame_replies();
		test_point_flags();
		led_stretch_times();
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* wfd_front.f */
logic/board_pkg.sv
logic/token_pkg.sv
logic/reset_gen.sv
logic/token_rcv.sv
logic/gtp_lane_io.sv
logic/led_stretch.sv
logic/led_panel.sv
logic/wfd_front.sv
verification/tb_wfd_front.sv

/* Bender.yml */
package:
  name: wfd_front

sources:
  - logic/board_pkg.sv
  - logic/token_pkg.sv
  - logic/reset_gen.sv
  - logic/token_rcv.sv
  - logic/gtp_lane_io.sv
  - logic/led_stretch.sv
  - logic/led_panel.sv
  - logic/wfd_front.sv
  - target: test
    files:
      - verification/tb_wfd_front.sv
